//--- dcache_config.svh
// cache geometry; sets and words per line must be powers of two, words are 32 bits
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// associativity
`define DCACHE_WAYS 4

// sets per way
`define DCACHE_SETS 16

// 32-bit words in one line
`define DCACHE_WORDS_PER_LINE 4

// byte address width
`define DCACHE_ADDR_W 32

// cycles of the invalidate walk after reset, one set per cycle
`define DCACHE_RESET_CYCLES `DCACHE_SETS

`endif

//--- mem_bus_pkg.sv
// CPU and line bus types; data words are fixed at 32 bits with four byte enables
`include "dcache_config.svh"

package mem_bus_pkg;

    // byte address
    typedef logic [`DCACHE_ADDR_W-1:0] addr_t;

    // one data word
    typedef logic [31:0] word_t;

    // byte enables of a word store
    typedef logic [3:0] be_t;

    // whole line, word 0 sits in the low bits
    typedef word_t [`DCACHE_WORDS_PER_LINE-1:0] line_t;

    // CPU operation
    typedef enum logic {
        CPU_LOAD  = 1'b0,
        CPU_STORE = 1'b1
    } cpu_op_e;

endpackage

//--- dcache_pkg.sv
// cache internal types; tag width follows from the address width and geometry macros
`include "dcache_config.svh"

package dcache_pkg;

    // controller states
    typedef enum logic [2:0] {
        ST_RESET,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL,
        ST_RESPOND
    } dcache_state_e;

    typedef logic [$clog2(`DCACHE_SETS)-1:0] index_t;
    typedef logic [$clog2(`DCACHE_WORDS_PER_LINE)-1:0] offset_t;

    // address bits above index, offset and byte
    typedef logic [`DCACHE_ADDR_W - $clog2(`DCACHE_SETS)
                   - $clog2(`DCACHE_WORDS_PER_LINE) - 3:0] tag_t;

    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;
    typedef logic [`DCACHE_WAYS-1:0] way_mask_t;

    // one tag ram entry
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    // root, left pair, right pair
    typedef logic [2:0] plru_bits_t;

endpackage

//--- dcache_tag_array.sv
// tag storage per way, no reset of contents; the controller invalidates all sets after reset
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_tag_array (
    input  logic                                      clk,
    input  logic                                      rst,
    input  dcache_pkg::index_t                        rd_index_i,
    input  dcache_pkg::tag_t                          rd_tag_i,
    input  dcache_pkg::way_mask_t                     wr_en_i,
    input  dcache_pkg::index_t                        wr_index_i,
    input  dcache_pkg::tag_entry_t                    wr_entry_i,
    output dcache_pkg::tag_entry_t [`DCACHE_WAYS-1:0] entries_o,
    output dcache_pkg::way_mask_t                     hit_o
);
    import dcache_pkg::*;

    tag_entry_t mem_q [`DCACHE_WAYS][`DCACHE_SETS];
    tag_entry_t [`DCACHE_WAYS-1:0] rd_q;
    tag_t       tag_q;
    way_mask_t  fwd_q;
    tag_entry_t fwd_entry_q;

    // storage and synchronous read
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (wr_en_i[w]) begin
                mem_q[w][wr_index_i] <= wr_entry_i;
            end
            rd_q[w] <= mem_q[w][rd_index_i];
        end
        tag_q       <= rd_tag_i;
        fwd_entry_q <= wr_entry_i;
    end

    // remember which ways were written into the set being read
    always_ff @(posedge clk) begin
        if (rst) begin
            fwd_q <= '0;
        end else begin
            fwd_q <= wr_en_i & {`DCACHE_WAYS{wr_index_i == rd_index_i}};
        end
    end

    // written entry replaces the stale ram output
    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : gen_way
        assign entries_o[w] = fwd_q[w] ? fwd_entry_q : rd_q[w];
        assign hit_o[w]     = entries_o[w].valid && (entries_o[w].tag == tag_q);
    end

endmodule

//--- dcache_data_array.sv
// line storage per way, whole-line writes only; byte merging happens in the controller
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_data_array (
    input  logic                                  clk,
    input  dcache_pkg::index_t                    rd_index_i,
    input  dcache_pkg::way_mask_t                 wr_way_i,
    input  dcache_pkg::index_t                    wr_index_i,
    input  mem_bus_pkg::line_t                    wr_line_i,
    output mem_bus_pkg::line_t [`DCACHE_WAYS-1:0] line_o
);
    import mem_bus_pkg::*;

    line_t mem_q [`DCACHE_WAYS][`DCACHE_SETS];
    line_t [`DCACHE_WAYS-1:0] rd_q;
    logic  [`DCACHE_WAYS-1:0] fwd_q;
    line_t fwd_line_q;

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (wr_way_i[w]) begin
                mem_q[w][wr_index_i] <= wr_line_i;
            end
            rd_q[w] <= mem_q[w][rd_index_i];
        end
        // read-during-write of one set
        fwd_q      <= wr_way_i & {`DCACHE_WAYS{wr_index_i == rd_index_i}};
        fwd_line_q <= wr_line_i;
    end

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : gen_way
        assign line_o[w] = fwd_q[w] ? fwd_line_q : rd_q[w];
    end

endmodule

//--- dcache_plru.sv
// tree pseudo-LRU for exactly four ways; the victim output is combinational on the lookup set
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_plru (
    input  logic               clk,
    input  logic               rst,
    input  logic               access_i,
    input  dcache_pkg::index_t access_index_i,
    input  dcache_pkg::way_t   access_way_i,
    input  dcache_pkg::index_t lookup_index_i,
    output dcache_pkg::way_t   victim_o
);
    import dcache_pkg::*;

    plru_bits_t bits_q [`DCACHE_SETS];
    plru_bits_t cur;

    // point the tree away from the used way
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                bits_q[s] <= '0;
            end
        end else if (access_i) begin
            bits_q[access_index_i][0] <= ~access_way_i[1];
            if (access_way_i[1]) begin
                bits_q[access_index_i][2] <= ~access_way_i[0];
            end else begin
                bits_q[access_index_i][1] <= ~access_way_i[0];
            end
        end
    end

    // follow the bits from the root
    always_comb begin
        cur = bits_q[lookup_index_i];
        if (cur[0]) begin
            victim_o = {1'b1, cur[2]};
        end else begin
            victim_o = {1'b0, cur[1]};
        end
    end

endmodule

//--- dcache_ctrl.sv
// one miss at a time; stores respond with nothing, loads respond in order, memory ack ends a request
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      req_valid_i,
    input  mem_bus_pkg::cpu_op_e                      req_op_i,
    input  mem_bus_pkg::addr_t                        req_addr_i,
    input  mem_bus_pkg::word_t                        req_wdata_i,
    input  mem_bus_pkg::be_t                          req_be_i,
    output logic                                      req_ready_o,
    output logic                                      resp_valid_o,
    output mem_bus_pkg::word_t                        resp_rdata_o,
    output logic                                      mem_req_o,
    output logic                                      mem_we_o,
    output mem_bus_pkg::addr_t                        mem_addr_o,
    output mem_bus_pkg::line_t                        mem_wline_o,
    input  logic                                      mem_ack_i,
    input  mem_bus_pkg::line_t                        mem_rline_i,
    output dcache_pkg::index_t                        rd_index_o,
    output dcache_pkg::tag_t                          rd_tag_o,
    output dcache_pkg::way_mask_t                     tag_wr_en_o,
    output dcache_pkg::index_t                        tag_wr_index_o,
    output dcache_pkg::tag_entry_t                    tag_wr_entry_o,
    input  dcache_pkg::tag_entry_t [`DCACHE_WAYS-1:0] entries_i,
    input  dcache_pkg::way_mask_t                     hit_i,
    output dcache_pkg::way_mask_t                     data_wr_way_o,
    output dcache_pkg::index_t                        data_wr_index_o,
    output mem_bus_pkg::line_t                        data_wr_line_o,
    input  mem_bus_pkg::line_t [`DCACHE_WAYS-1:0]     lines_i,
    output logic                                      plru_access_o,
    output dcache_pkg::index_t                        plru_index_o,
    output dcache_pkg::way_t                          plru_way_o,
    input  dcache_pkg::way_t                          victim_i
);
    import mem_bus_pkg::*;
    import dcache_pkg::*;

    localparam int IDX_LSB = 2 + $bits(offset_t);
    localparam int TAG_LSB = IDX_LSB + $bits(index_t);

    function automatic index_t addr_index(addr_t addr);
        return addr[IDX_LSB +: $bits(index_t)];
    endfunction

    function automatic tag_t addr_tag(addr_t addr);
        return addr[TAG_LSB +: $bits(tag_t)];
    endfunction

    function automatic offset_t addr_offset(addr_t addr);
        return addr[2 +: $bits(offset_t)];
    endfunction

    // merge enabled store bytes into one word of the line
    function automatic line_t merge_store(line_t line, offset_t off, word_t wdata, be_t be);
        line_t merged;
        merged = line;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                merged[off][8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return merged;
    endfunction

    dcache_state_e state_q, state_n;
    index_t  walk_q;
    logic    mem_req_q;
    logic    lk_valid_q;
    cpu_op_e lk_op_q;
    addr_t   lk_addr_q;
    word_t   lk_wdata_q;
    be_t     lk_be_q;
    way_t    vic_way_q;
    tag_t    vic_tag_q;
    line_t   vic_line_q;
    word_t   fill_word_q;
    logic    lk_hit;
    logic    lk_miss;
    logic    fill_done;
    way_t    hit_way;
    way_t    pick_way;
    line_t   hit_line;
    addr_t   rd_addr;

    // hit decode, and an invalid way wins over the PLRU victim
    always_comb begin
        hit_way  = '0;
        hit_line = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (hit_i[w]) begin
                hit_way  = way_t'(w);
                hit_line = lines_i[w];
            end
        end
        pick_way = victim_i;
        for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
            if (!entries_i[w].valid) begin
                pick_way = way_t'(w);
            end
        end
    end

    assign lk_hit    = (state_q == ST_LOOKUP) && lk_valid_q && (|hit_i);
    assign lk_miss   = (state_q == ST_LOOKUP) && lk_valid_q && !(|hit_i);
    assign fill_done = (state_q == ST_REFILL) && mem_req_q && mem_ack_i;

    // a new request can enter whenever the lookup stage empties this cycle
    assign req_ready_o = ((state_q == ST_LOOKUP) && !lk_miss) || (state_q == ST_RESPOND);
    assign rd_addr     = req_ready_o ? req_addr_i : lk_addr_q;
    assign rd_index_o  = addr_index(rd_addr);
    assign rd_tag_o    = addr_tag(rd_addr);

    assign resp_valid_o = (lk_op_q == CPU_LOAD) && (lk_hit || (state_q == ST_RESPOND));
    assign resp_rdata_o = (state_q == ST_RESPOND) ? fill_word_q
                                                  : hit_line[addr_offset(lk_addr_q)];

    // line port
    assign mem_req_o   = mem_req_q;
    assign mem_we_o    = (state_q == ST_WRITEBACK);
    assign mem_wline_o = vic_line_q;
    assign mem_addr_o  = (state_q == ST_WRITEBACK)
                       ? {vic_tag_q, addr_index(lk_addr_q), {IDX_LSB{1'b0}}}
                       : {lk_addr_q[`DCACHE_ADDR_W-1:IDX_LSB], {IDX_LSB{1'b0}}};

    assign plru_index_o = addr_index(lk_addr_q);

    // array writes and replacement updates
    always_comb begin
        tag_wr_en_o     = '0;
        tag_wr_index_o  = addr_index(lk_addr_q);
        tag_wr_entry_o  = '{valid: 1'b1, dirty: 1'b1, tag: addr_tag(lk_addr_q)};
        data_wr_way_o   = '0;
        data_wr_index_o = addr_index(lk_addr_q);
        data_wr_line_o  = merge_store(hit_line, addr_offset(lk_addr_q), lk_wdata_q, lk_be_q);
        plru_access_o   = 1'b0;
        plru_way_o      = hit_way;
        case (state_q)
            ST_RESET: begin
                tag_wr_en_o    = '1;
                tag_wr_index_o = walk_q;
                tag_wr_entry_o = '0;
            end
            ST_LOOKUP: begin
                plru_access_o = lk_hit;
                if (lk_hit && lk_op_q == CPU_STORE) begin
                    tag_wr_en_o   = hit_i;
                    data_wr_way_o = hit_i;
                end
            end
            ST_REFILL: begin
                tag_wr_entry_o.dirty = (lk_op_q == CPU_STORE);
                data_wr_line_o       = mem_rline_i;
                if (lk_op_q == CPU_STORE) begin
                    data_wr_line_o = merge_store(mem_rline_i, addr_offset(lk_addr_q),
                                                 lk_wdata_q, lk_be_q);
                end
                if (fill_done) begin
                    tag_wr_en_o[vic_way_q]   = 1'b1;
                    data_wr_way_o[vic_way_q] = 1'b1;
                    plru_access_o            = 1'b1;
                    plru_way_o               = vic_way_q;
                end
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        state_n = state_q;
        case (state_q)
            ST_RESET: begin
                if (walk_q == index_t'(`DCACHE_RESET_CYCLES - 1)) begin
                    state_n = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (lk_miss) begin
                    state_n = entries_i[pick_way].dirty && entries_i[pick_way].valid
                            ? ST_WRITEBACK : ST_REFILL;
                end
            end
            ST_WRITEBACK: begin
                if (mem_req_q && mem_ack_i) begin
                    state_n = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (fill_done) begin
                    state_n = ST_RESPOND;
                end
            end
            default: begin
                state_n = ST_LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ST_RESET;
            walk_q     <= '0;
            lk_valid_q <= 1'b0;
            mem_req_q  <= 1'b0;
        end else begin
            state_q <= state_n;
            if (state_q == ST_RESET) begin
                walk_q <= walk_q + 1'b1;
            end
            if (req_ready_o) begin
                lk_valid_q <= req_valid_i;
            end
            // request drops for one cycle after every ack
            if (mem_req_q) begin
                if (mem_ack_i) begin
                    mem_req_q <= 1'b0;
                end
            end else if (state_n == ST_WRITEBACK || state_n == ST_REFILL) begin
                mem_req_q <= 1'b1;
            end
        end
    end

    // request, victim and fill payload
    always_ff @(posedge clk) begin
        if (req_ready_o && req_valid_i) begin
            lk_op_q    <= req_op_i;
            lk_addr_q  <= req_addr_i;
            lk_wdata_q <= req_wdata_i;
            lk_be_q    <= req_be_i;
        end
        if (lk_miss) begin
            vic_way_q  <= pick_way;
            vic_tag_q  <= entries_i[pick_way].tag;
            vic_line_q <= lines_i[pick_way];
        end
        if (fill_done) begin
            fill_word_q <= mem_rline_i[addr_offset(lk_addr_q)];
        end
    end

endmodule

//--- dcache_top.sv
// data cache top; one outstanding line transfer, memory must answer every request with an ack
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid_i,
    input  mem_bus_pkg::cpu_op_e req_op_i,
    input  mem_bus_pkg::addr_t   req_addr_i,
    input  mem_bus_pkg::word_t   req_wdata_i,
    input  mem_bus_pkg::be_t     req_be_i,
    output logic                 req_ready_o,
    output logic                 resp_valid_o,
    output mem_bus_pkg::word_t   resp_rdata_o,
    output logic                 mem_req_o,
    output logic                 mem_we_o,
    output mem_bus_pkg::addr_t   mem_addr_o,
    output mem_bus_pkg::line_t   mem_wline_o,
    input  logic                 mem_ack_i,
    input  mem_bus_pkg::line_t   mem_rline_i
);
    import mem_bus_pkg::*;
    import dcache_pkg::*;

    index_t     rd_index;
    tag_t       rd_tag;
    way_mask_t  tag_wr_en;
    index_t     tag_wr_index;
    tag_entry_t tag_wr_entry;
    tag_entry_t [`DCACHE_WAYS-1:0] entries;
    way_mask_t  hit;
    way_mask_t  data_wr_way;
    index_t     data_wr_index;
    line_t      data_wr_line;
    line_t [`DCACHE_WAYS-1:0] lines;
    logic       plru_access;
    index_t     plru_index;
    way_t       plru_way;
    way_t       victim;

    dcache_ctrl ctrl0 (
        .clk, .rst,
        .req_valid_i, .req_op_i, .req_addr_i, .req_wdata_i, .req_be_i,
        .req_ready_o, .resp_valid_o, .resp_rdata_o,
        .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wline_o, .mem_ack_i, .mem_rline_i,
        .rd_index_o      (rd_index),
        .rd_tag_o        (rd_tag),
        .tag_wr_en_o     (tag_wr_en),
        .tag_wr_index_o  (tag_wr_index),
        .tag_wr_entry_o  (tag_wr_entry),
        .entries_i       (entries),
        .hit_i           (hit),
        .data_wr_way_o   (data_wr_way),
        .data_wr_index_o (data_wr_index),
        .data_wr_line_o  (data_wr_line),
        .lines_i         (lines),
        .plru_access_o   (plru_access),
        .plru_index_o    (plru_index),
        .plru_way_o      (plru_way),
        .victim_i        (victim)
    );

    dcache_tag_array tags0 (
        .clk, .rst,
        .rd_index_i (rd_index),
        .rd_tag_i   (rd_tag),
        .wr_en_i    (tag_wr_en),
        .wr_index_i (tag_wr_index),
        .wr_entry_i (tag_wr_entry),
        .entries_o  (entries),
        .hit_o      (hit)
    );

    dcache_data_array data0 (
        .clk,
        .rd_index_i (rd_index),
        .wr_way_i   (data_wr_way),
        .wr_index_i (data_wr_index),
        .wr_line_i  (data_wr_line),
        .line_o     (lines)
    );

    // accesses and victim lookups both concern the set in the lookup stage
    dcache_plru plru0 (
        .clk, .rst,
        .access_i       (plru_access),
        .access_index_i (plru_index),
        .access_way_i   (plru_way),
        .lookup_index_i (plru_index),
        .victim_o       (victim)
    );

endmodule

//--- dcache_props.sv
// CPU and memory handshake rules only; assumes one response per accepted load
`timescale 1ns/1ps

module dcache_props (
    input logic                 clk,
    input logic                 rst,
    input logic                 req_valid_i,
    input mem_bus_pkg::cpu_op_e req_op_i,
    input logic                 req_ready_i,
    input logic                 resp_valid_i,
    input logic                 mem_req_i,
    input logic                 mem_we_i,
    input mem_bus_pkg::addr_t   mem_addr_i,
    input mem_bus_pkg::line_t   mem_wline_i,
    input logic                 mem_ack_i
);
    import mem_bus_pkg::*;

    int unsigned loads_open_q;
    int unsigned assert_fails = 0;

    // accepted loads still owed a response
    always_ff @(posedge clk) begin
        if (rst) begin
            loads_open_q <= 0;
        end else begin
            loads_open_q <= loads_open_q
                          + ((req_valid_i && req_ready_i && req_op_i == CPU_LOAD) ? 1 : 0)
                          - (resp_valid_i ? 1 : 0);
        end
    end

    // memory request and its fields held until the ack edge
    assert property (@(posedge clk) disable iff (rst)
        mem_req_i && !mem_ack_i |=> mem_req_i && $stable(mem_we_i)
                                    && $stable(mem_addr_i) && $stable(mem_wline_i))
    else begin
        $error("memory request changed before it was acknowledged");
        assert_fails++;
    end

    assert property (@(posedge clk) rst |=> !req_ready_i && !mem_req_i && !resp_valid_i)
    else begin
        $error("handshake output high during reset");
        assert_fails++;
    end

    assert property (@(posedge clk) disable iff (rst) resp_valid_i |-> loads_open_q != 0)
    else begin
        $error("response without an accepted load");
        assert_fails++;
    end

endmodule

bind dcache_top dcache_props props0 (
    .clk          (clk),
    .rst          (rst),
    .req_valid_i  (req_valid_i),
    .req_op_i     (req_op_i),
    .req_ready_i  (req_ready_o),
    .resp_valid_i (resp_valid_o),
    .mem_req_i    (mem_req_o),
    .mem_we_i     (mem_we_o),
    .mem_addr_i   (mem_addr_o),
    .mem_wline_i  (mem_wline_o),
    .mem_ack_i    (mem_ack_i)
);

//--- tb_dcache.sv
// testbench for dcache_top; memory delays of 0 to 7 cycles, every wait gives up after TIMEOUT cycles
`timescale 1ns/1ps
`include "dcache_config.svh"

module tb_dcache;
    import mem_bus_pkg::*;
    import dcache_pkg::*;

    localparam int TIMEOUT = 200;

    logic    clk = 1'b0;
    logic    rst = 1'b1;
    logic    req_valid_i = 1'b0;
    cpu_op_e req_op_i = CPU_LOAD;
    addr_t   req_addr_i = '0;
    word_t   req_wdata_i = '0;
    be_t     req_be_i = '0;
    logic    req_ready_o;
    logic    resp_valid_o;
    word_t   resp_rdata_o;
    logic    mem_req_o;
    logic    mem_we_o;
    addr_t   mem_addr_o;
    line_t   mem_wline_o;
    logic    mem_ack_i = 1'b0;
    line_t   mem_rline_i = '0;

    word_t       mem_img [addr_t];
    word_t       ref_img [addr_t];
    word_t       exp_q [$];
    logic [15:0] stim_lfsr = 16'd62;
    logic [15:0] mem_lfsr = 16'd62;
    int          mem_wait = -1;
    int          checks = 0;
    int          errors = 0;
    int          writebacks = 0;

    dcache_top dut0 (.*);

    always #10 clk = ~clk;

    // every address bit reaches the data
    function automatic word_t fill_pattern(addr_t addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h6b3c_a519;
    endfunction

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(inout logic [15:0] s, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_step(s);
            v = {v[30:0], s[0]};
        end
        return v;
    endfunction

    function automatic addr_t make_addr(int tag, int set, int off);
        return {tag_t'(tag), index_t'(set), offset_t'(off), 2'b00};
    endfunction

    // CPU view of memory where a store takes effect when it is accepted
    function automatic word_t ref_access(cpu_op_e op, addr_t addr, word_t wdata, be_t be);
        addr_t a;
        word_t w;
        a = {addr[31:2], 2'b00};
        w = ref_img.exists(a) ? ref_img[a] : fill_pattern(a);
        if (op == CPU_STORE) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    w[8*b +: 8] = wdata[8*b +: 8];
                end
            end
            ref_img[a] = w;
        end
        return w;
    endfunction

    function automatic line_t ref_line(addr_t base);
        line_t line;
        for (int w = 0; w < `DCACHE_WORDS_PER_LINE; w++) begin
            line[w] = ref_access(CPU_LOAD, base + addr_t'(4 * w), '0, '0);
        end
        return line;
    endfunction

    task automatic check_word(string what, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s returned %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_line(string what, line_t got, line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s carried %h, expected %h", $time, what, got, exp);
        end
    endtask

    // answer the request seen at this edge
    task automatic serve_line();
        line_t line;
        if (mem_we_o) begin
            writebacks++;
            check_line("write-back", mem_wline_o, ref_line(mem_addr_o));
            for (int w = 0; w < `DCACHE_WORDS_PER_LINE; w++) begin
                mem_img[mem_addr_o + addr_t'(4 * w)] = mem_wline_o[w];
            end
        end else begin
            for (int w = 0; w < `DCACHE_WORDS_PER_LINE; w++) begin
                addr_t a;
                a = mem_addr_o + addr_t'(4 * w);
                line[w] = mem_img.exists(a) ? mem_img[a] : fill_pattern(a);
            end
            mem_rline_i <= line;
        end
    endtask

    // line memory with a random delay per request
    always @(posedge clk) begin
        if (mem_ack_i) begin
            mem_ack_i <= 1'b0;
            mem_wait = -1;
        end else if (mem_req_o) begin
            if (mem_wait < 0) begin
                mem_wait = int'(take_bits(mem_lfsr, 3));
            end
            if (mem_wait == 0) begin
                serve_line();
                mem_ack_i <= 1'b1;
            end
            mem_wait = mem_wait - 1;
        end
    end

    // responses checked in order against expected loads
    always @(posedge clk) begin
        if (resp_valid_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("response at %0t ns with no load waiting for one", $time);
            end else begin
                check_word("load response", resp_rdata_o, exp_q.pop_front());
            end
        end
    end

    // present one request and wait for the edge that takes it
    task automatic cpu_access(cpu_op_e op, addr_t addr, word_t wdata, be_t be);
        int    cycles;
        word_t exp;
        req_valid_i <= 1'b1;
        req_op_i    <= op;
        req_addr_i  <= addr;
        req_wdata_i <= wdata;
        req_be_i    <= be;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!req_ready_o && cycles < TIMEOUT);
        if (!req_ready_o) begin
            errors++;
            $display("timeout at %0t ns, request to %h was never accepted", $time, addr);
        end else begin
            exp = ref_access(op, addr, wdata, be);
            if (op == CPU_LOAD) begin
                exp_q.push_back(exp);
            end
        end
    endtask

    task automatic idle_cycle();
        req_valid_i <= 1'b0;
        @(posedge clk);
    endtask

    // wait until all loads answered and no miss is pending
    task automatic drain();
        int cycles;
        req_valid_i <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!(req_ready_o && !resp_valid_o && exp_q.size() == 0) && cycles < TIMEOUT);
        if (!(req_ready_o && !resp_valid_o && exp_q.size() == 0)) begin
            errors++;
            $display("timeout at %0t ns, %0d loads still without response", $time, exp_q.size());
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        $display("test %s: %s", name, (errors == errors_before) ? "ok" : "FAIL");
    endtask

    initial begin
        int      base;
        int      wb_base;
        int      set;
        int      tag;
        int      off;
        cpu_op_e op;
        word_t   wdata;
        be_t     be;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        base = errors;
        for (int i = 0; i < 8; i++) begin
            cpu_access(CPU_LOAD, make_addr('ha00 + i, i, i % 4), '0, '0);
        end
        drain();
        finish_test("1 cold load misses", base);

        // hit store into set 2 and then a miss store into set 6
        base = errors;
        cpu_access(CPU_STORE, make_addr('ha02, 2, 1), 32'hdead_beef, 4'b0101);
        cpu_access(CPU_LOAD, make_addr('ha02, 2, 1), '0, '0);
        cpu_access(CPU_STORE, make_addr('h300, 6, 3), 32'h1234_5678, 4'b1010);
        cpu_access(CPU_LOAD, make_addr('h300, 6, 3), '0, '0);
        drain();
        finish_test("2 partial stores", base);

        base = errors;
        for (int i = 0; i < 8; i++) begin
            cpu_access(CPU_LOAD, make_addr('ha00, 0, (i < 4) ? i : 7 - i), '0, '0);
        end
        drain();
        finish_test("3 back-to-back hits", base);

        // five tags in set 12 overflow four ways
        base = errors;
        wb_base = writebacks;
        for (int i = 0; i < 5; i++) begin
            cpu_access(CPU_STORE, make_addr('h200 + i, 12, i % 4), 32'hc0de_0000 + i, 4'hf);
        end
        for (int i = 0; i < 5; i++) begin
            cpu_access(CPU_LOAD, make_addr('h200 + i, 12, i % 4), '0, '0);
        end
        drain();
        if (writebacks == wb_base) begin
            errors++;
            $display("no write-back seen after filling five lines of one set");
        end
        finish_test("4 dirty eviction", base);

        base = errors;
        for (int i = 0; i < 200; i++) begin
            if (take_bits(stim_lfsr, 2) == 0) begin
                idle_cycle();
            end
            set   = 1 + int'(take_bits(stim_lfsr, 2)) % 3;
            tag   = 'h400 + int'(take_bits(stim_lfsr, 3)) % 6;
            op    = (take_bits(stim_lfsr, 1) != 0) ? CPU_STORE : CPU_LOAD;
            off   = int'(take_bits(stim_lfsr, 2));
            wdata = take_bits(stim_lfsr, 32);
            be    = be_t'(take_bits(stim_lfsr, 4));
            cpu_access(op, make_addr(tag, set, off), wdata, be);
        end
        drain();
        finish_test("5 random mix", base);

        errors = errors + int'(dut0.props0.assert_fails);
        $display("checks %0d, errors %0d, write-backs %0d", checks, errors, writebacks);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+.
mem_bus_pkg.sv
dcache_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_plru.sv
dcache_ctrl.sv
dcache_top.sv
dcache_props.sv
tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f list.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dcache +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$log"; then
    exit 1
fi
exit 0
